// File: Makefile
# Verilator flow for the branch predictor testbench

VERILATOR ?= verilator
TOP       := tb_branch_predictor
FILELIST  := all.f
FLAGS     := --timing --assert --timescale 1ns/1ps -Wno-fatal
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The log decides the result, the exit status of the run is not trusted
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '>>> PASS' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+common
+incdir+tests
common/bp_pkg.sv
common/train_if.sv
source/retire_queue.sv
predictor/history_table.sv
source/branch_predictor.sv
tests/tb_branch_predictor.sv

// File: common/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Instruction address width and the number of fetch / retire lanes
`define BP_ADDR_WIDTH 32
`define BP_LANES 4

// Retire buffer size and its pointer width, without the wrap bit
`define BP_QUEUE_DEPTH 16
`define BP_QUEUE_PTR 4

// Table index is {low pc bits, global history}
`define BP_PC_BITS 7
`define BP_HIST_BITS 2
// Sum of the two widths above
`define BP_INDEX_BITS 9
`define BP_ENTRIES 512

// Every counter starts weakly not-taken
`define BP_CTR_INIT 1

`endif

// File: common/bp_pkg.sv
package bp_pkg;

	`include "bp_consts.svh"

	// ============================
	// Table index
	// ============================

	// One word, read two ways
	// The flat view addresses the counter array and steps the reset sweep
	// The field view is used when an index is put together from a fetch
	// or retire address and the global history register
	typedef union packed
	{
		logic [`BP_INDEX_BITS-1:0] flat;
		struct packed
		{
			// Low address bits sit in the upper part of the index
			logic [`BP_PC_BITS-1:0] pc_part;
			// History bits select among the counters of one address
			logic [`BP_HIST_BITS-1:0] hist_part;
		} fields;
	} pht_index_u;

endpackage

// File: common/train_if.sv
`include "bp_consts.svh"

// One training record per cycle from the retire queue to the counter table
// A record is consumed on every cycle where valid is high and hold is low
interface train_if;

	// Record strobe, high for each cycle a record is offered
	logic valid;
	// Resolved direction of the retired branch
	logic taken;
	// Address of the retired branch
	logic [`BP_ADDR_WIDTH-1:0] pc;
	// Stall level from the table, the source keeps its record while high
	logic hold;

	// Retire queue side
	modport source
	(
		output valid, taken, pc,
		input hold
	);

	// Counter table side
	modport sink
	(
		input valid, taken, pc,
		output hold
	);

endinterface

// File: predictor/history_table.sv
`include "bp_consts.svh"

module history_table
(
	input logic clk,
	input logic rst,
	input logic en,
	input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] fetch_pc,
	output logic [`BP_LANES-1:0] predict_taken,
	output logic ready,
	train_if.sink train
);

	import bp_pkg::*;

	// ============================
	// State
	// ============================

	// Two-bit saturating counters, 0 and 1 predict not-taken, 2 and 3 taken
	logic [1:0] pht [`BP_ENTRIES];

	// Global history with the newest outcome in bit 0
	logic [`BP_HIST_BITS-1:0] ghr;

	// Sweep runs from reset until every counter holds its initial value
	logic sweeping;
	pht_index_u sweep_idx;

	// Lookup indices, one per fetch lane
	pht_index_u rd_idx [`BP_LANES];

	// Training side
	pht_index_u upd_idx;
	logic [1:0] upd_ctr;
	logic [1:0] upd_ctr_next;
	logic upd_we;

	// ============================
	// Stall toward the queue
	// ============================

	// Training waits for the sweep and for en
	assign train.hold = sweeping || !en;
	assign upd_we = train.valid && !train.hold;
	assign ready = !sweeping;

	// ============================
	// Lookup
	// ============================

	// Purely combinational, each lane sees the current history and table
	always_comb
	begin
		for (int i = 0; i < `BP_LANES; i++)
		begin
			rd_idx[i].fields.pc_part = fetch_pc[i][`BP_PC_BITS-1:0];
			rd_idx[i].fields.hist_part = ghr;
			// Upper counter bit is the prediction, forced off until usable
			predict_taken[i] = en && ready && pht[rd_idx[i].flat][1];
		end
	end

	// ============================
	// Training
	// ============================

	// Update index uses the history from before this record is shifted in
	always_comb
	begin
		upd_idx.fields.pc_part = train.pc[`BP_PC_BITS-1:0];
		upd_idx.fields.hist_part = ghr;
	end

	assign upd_ctr = pht[upd_idx.flat];

	// Saturate at both ends instead of wrapping
	always_comb
	begin
		if (train.taken)
			upd_ctr_next = (upd_ctr == 2'd3) ? upd_ctr : upd_ctr + 2'd1;
		else
			upd_ctr_next = (upd_ctr == 2'd0) ? upd_ctr : upd_ctr - 2'd1;
	end

	// Sweep and training never write in the same cycle since hold covers the sweep
	always_ff @(posedge clk)
	begin
		if (sweeping)
			pht[sweep_idx.flat] <= 2'(`BP_CTR_INIT);
		else if (upd_we)
			pht[upd_idx.flat] <= upd_ctr_next;
	end

	// Shift the resolved direction in on the same edge as the counter write
	always_ff @(posedge clk)
	begin
		if (rst)
			ghr <= '0;
		else if (upd_we)
			ghr <= {ghr[`BP_HIST_BITS-2:0], train.taken};
	end

	// ============================
	// Reset sweep
	// ============================

	// One entry per cycle, BP_ENTRIES cycles in all after rst falls
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			sweeping <= 1'b1;
			sweep_idx.flat <= '0;
		end
		else if (sweeping)
		begin
			sweep_idx.flat <= sweep_idx.flat + 1'b1;
			// Last entry written, ready follows in the next cycle
			if (sweep_idx.flat == (`BP_ENTRIES - 1))
				sweeping <= 1'b0;
		end
	end

	// ============================
	// Checks
	// ============================

	// A stalled table keeps the addressed counter and the history untouched
	assert property (@(posedge clk) disable iff (rst)
		!sweeping && train.hold |=>
		$stable(ghr) && (pht[$past(upd_idx.flat)] == $past(upd_ctr)))
	else
		$error("history_table written while hold is high");

	// A stalled record has to stay put on the bus until it is taken
	assert property (@(posedge clk) disable iff (rst)
		train.valid && train.hold |=> train.valid && $stable(train.pc) && $stable(train.taken))
	else
		$error("training record changed while held");

endmodule

// File: source/branch_predictor.sv
`include "bp_consts.svh"

module branch_predictor
(
	input logic clk,
	input logic rst,
	// Lookup and training enable
	input logic en,
	// Up to four retired branches per cycle, lane 0 oldest
	input logic [`BP_LANES-1:0] retire_valid,
	input logic [`BP_LANES-1:0] retire_taken,
	input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] retire_pc,
	// Four fetch lanes, predictions are combinational
	input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] fetch_pc,
	output logic [`BP_LANES-1:0] predict_taken,
	// High once the reset sweep has finished
	output logic ready
);

	// ============================
	// Retire to table link
	// ============================

	// Carries one record per cycle from the queue into the table
	train_if train_bus();

	// Packs retired branches in lane order and drains one per cycle
	retire_queue retire_queue_inst
	(
		.clk(clk),
		.rst(rst),
		.retire_valid(retire_valid),
		.retire_taken(retire_taken),
		.retire_pc(retire_pc),
		.train(train_bus.source)
	);

	// ============================
	// Counter table
	// ============================

	// Holds the counters and history, stalls the queue while busy
	history_table history_table_inst
	(
		.clk(clk),
		.rst(rst),
		.en(en),
		.fetch_pc(fetch_pc),
		.predict_taken(predict_taken),
		.ready(ready),
		.train(train_bus.sink)
	);

endmodule

// File: source/retire_queue.sv
`include "bp_consts.svh"

module retire_queue
(
	input logic clk,
	input logic rst,
	input logic [`BP_LANES-1:0] retire_valid,
	input logic [`BP_LANES-1:0] retire_taken,
	input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] retire_pc,
	train_if.source train
);

	// Pointer width including the wrap bit
	localparam int PTR_W = `BP_QUEUE_PTR + 1;
	// Enough bits to count every retire lane at once
	localparam int LANE_CNT_W = $clog2(`BP_LANES + 1);

	// ============================
	// Storage and pointers
	// ============================

	// Circular buffer holding the payload of retired branches
	logic [`BP_ADDR_WIDTH-1:0] pc_mem [`BP_QUEUE_DEPTH];
	logic [`BP_QUEUE_DEPTH-1:0] taken_mem;

	// The extra top bit tells a full buffer from an empty one
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [PTR_W-1:0] occupancy;
	logic empty;

	// Slot each lane lands in this cycle, and how many lanes retire
	logic [PTR_W-1:0] lane_ptr [`BP_LANES];
	logic [LANE_CNT_W-1:0] lane_cnt;

	// Output register may take a new record this cycle
	logic advance;

	assign occupancy = tail - head;
	assign empty = (head == tail);

	// ============================
	// Lane packing
	// ============================

	// Each set lane gets the next free slot after the set lanes below it,
	// so the buffer keeps ascending lane order without gaps
	always_comb
	begin
		lane_cnt = '0;
		for (int i = 0; i < `BP_LANES; i++)
		begin
			lane_ptr[i] = tail + PTR_W'(lane_cnt);
			lane_cnt = lane_cnt + LANE_CNT_W'(retire_valid[i]);
		end
	end

	// Buffer slots are written on the edge that samples the retire lanes
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `BP_LANES; i++)
		begin
			if (retire_valid[i])
			begin
				pc_mem[lane_ptr[i][`BP_QUEUE_PTR-1:0]] <= retire_pc[i];
				taken_mem[lane_ptr[i][`BP_QUEUE_PTR-1:0]] <= retire_taken[i];
			end
		end
	end

	// Tail moves past every slot written this cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			tail <= '0;
		else
			tail <= tail + PTR_W'(lane_cnt);
	end

	// ============================
	// Drain to the table
	// ============================

	// Load when nothing is offered, or when the offered record is consumed
	// A held record stays on the bus untouched
	assign advance = !train.valid || !train.hold;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			head <= '0;
			train.valid <= 1'b0;
		end
		else if (advance)
		begin
			if (!empty)
			begin
				head <= head + 1'b1;
				train.valid <= 1'b1;
			end
			else
				train.valid <= 1'b0;
		end
	end

	// Record payload follows the head entry
	always_ff @(posedge clk)
	begin
		if (advance && !empty)
		begin
			train.pc <= pc_mem[head[`BP_QUEUE_PTR-1:0]];
			train.taken <= taken_mem[head[`BP_QUEUE_PTR-1:0]];
		end
	end

	// ============================
	// Checks
	// ============================

	// There is no back-pressure toward the core, so it must never retire
	// more branches than the buffer has free slots
	assert property (@(posedge clk) disable iff (rst)
		occupancy + lane_cnt <= `BP_QUEUE_DEPTH)
	else
		$error("retire_queue overflow, occupancy %0d plus %0d lanes", occupancy, lane_cnt);

	// No record may leave the queue while it is being reset
	assert property (@(posedge clk) rst |=> !train.valid)
	else
		$error("retire_queue offered a record during reset");

endmodule

// File: tests/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

// ==============================
// Reference model state
// ==============================

// Retired branches still waiting in the buffer, oldest at the front
logic [`BP_ADDR_WIDTH-1:0] mdl_q_pc [$];
logic mdl_q_taken [$];

// Record offered to the counter table
logic mdl_out_valid;
logic [`BP_ADDR_WIDTH-1:0] mdl_out_pc;
logic mdl_out_taken;

// Global history, counters and reset sweep progress
logic [`BP_HIST_BITS-1:0] mdl_ghr;
logic [1:0] mdl_ctr [`BP_ENTRIES];
logic mdl_sweeping;
int mdl_sweep_cnt;
// Set once the first reset edge has been seen
logic mdl_live = 1'b0;

// One clock edge, all arguments are the values seen before the edge
task automatic model_step(input logic r, input logic e, input logic [`BP_LANES-1:0] rv,
	input logic [`BP_LANES-1:0] rt, input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] rp);
	logic hold;
	logic [`BP_INDEX_BITS-1:0] idx;
	if (r)
	begin
		mdl_q_pc.delete();
		mdl_q_taken.delete();
		mdl_out_valid = 1'b0;
		mdl_ghr = '0;
		mdl_sweeping = 1'b1;
		mdl_sweep_cnt = 0;
		mdl_live = 1'b1;
		// Counters are hidden until the sweep ends, so set them right away
		foreach (mdl_ctr[k])
			mdl_ctr[k] = 2'(`BP_CTR_INIT);
	end
	else
	begin
		hold = mdl_sweeping || !e;
		// Train with the history from before the shift
		if (mdl_out_valid && !hold)
		begin
			idx = {mdl_out_pc[`BP_PC_BITS-1:0], mdl_ghr};
			if (mdl_out_taken && mdl_ctr[idx] != 2'd3)
				mdl_ctr[idx] = mdl_ctr[idx] + 2'd1;
			else if (!mdl_out_taken && mdl_ctr[idx] != 2'd0)
				mdl_ctr[idx] = mdl_ctr[idx] - 2'd1;
			mdl_ghr = {mdl_ghr[`BP_HIST_BITS-2:0], mdl_out_taken};
		end
		if (mdl_sweeping)
		begin
			mdl_sweep_cnt++;
			if (mdl_sweep_cnt == `BP_ENTRIES)
				mdl_sweeping = 1'b0;
		end
		// A held record stays, otherwise the oldest waiting entry moves up
		if (!mdl_out_valid || !hold)
		begin
			mdl_out_valid = (mdl_q_pc.size() > 0);
			if (mdl_out_valid)
			begin
				mdl_out_pc = mdl_q_pc.pop_front();
				mdl_out_taken = mdl_q_taken.pop_front();
			end
		end
		// New retires land behind everything older, in lane order
		for (int i = 0; i < `BP_LANES; i++)
		begin
			if (rv[i])
			begin
				mdl_q_pc.push_back(rp[i]);
				mdl_q_taken.push_back(rt[i]);
			end
		end
	end
endtask

// Expected prediction for one fetch address, counters 2 and 3 mean taken
function automatic logic predict_ref(input logic e, input logic [`BP_ADDR_WIDTH-1:0] pc);
	logic [`BP_INDEX_BITS-1:0] idx;
	idx = {pc[`BP_PC_BITS-1:0], mdl_ghr};
	return e && !mdl_sweeping && (mdl_ctr[idx] >= 2'd2);
endfunction

// Free buffer slots right now
function automatic int free_room();
	return `BP_QUEUE_DEPTH - mdl_q_pc.size();
endfunction

`endif

// File: tests/tb_branch_predictor.sv
`include "bp_consts.svh"

module tb_branch_predictor;

	timeunit 1ns;
	timeprecision 100ps;

	// Two resets with their sweeps take about 1060 cycles, the tests about 1100 more
	localparam int CYCLE_LIMIT = 4000;

	logic clk;
	logic rst;
	logic en;
	logic [`BP_LANES-1:0] retire_valid;
	logic [`BP_LANES-1:0] retire_taken;
	logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] retire_pc;
	logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] fetch_pc;
	logic [`BP_LANES-1:0] predict_taken;
	logic ready;

	int cycle_cnt = 0;
	int error_cnt = 0;
	// Buffer room seen at the last falling edge, and lanes driven one edge ago
	int room_snap = 0;
	int last_cnt = 0;
	logic [`BP_ADDR_WIDTH-1:0] addr_a;
	logic [`BP_ADDR_WIDTH-1:0] addr_b;

	`include "bp_ref_model.svh"

	branch_predictor branch_predictor_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// ==============================
	// Checking
	// ==============================

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			error_cnt++;
			$display("FAILED at %0t ns: %s is %0h, expected %0h",
				$time, name, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	always @(posedge clk)
		model_step(rst, en, retire_valid, retire_taken, retire_pc);

	// Outputs have settled by the falling edge
	always @(negedge clk)
	begin
		room_snap = free_room();
		if (mdl_live)
		begin
			check_value("ready", ready, !mdl_sweeping);
			for (int i = 0; i < `BP_LANES; i++)
				check_value($sformatf("predict_taken[%0d]", i), predict_taken[i],
					predict_ref(en, fetch_pc[i]));
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display(">>> FAIL");
			$fatal(1, "Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		end
	end

	// ==============================
	// Stimulus helpers
	// ==============================

	// Holds rst for 16 cycles and counts the cycles until ready rises
	// Returns on a rising edge once the sweep is over
	task automatic reset_and_sweep();
		int lat;
		rst <= 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		lat = 0;
		@(negedge clk);
		while (!ready)
		begin
			lat++;
			@(negedge clk);
		end
		check_value("ready_latency", lat, `BP_ENTRIES);
		@(posedge clk);
	endtask

	// Called on a rising edge, lanes beyond the buffer room are dropped
	task automatic retire_cycle(input logic [`BP_LANES-1:0] mask,
		input logic [`BP_LANES-1:0] taken, input logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] pcs);
		logic [`BP_LANES-1:0] fit;
		int room;
		room = room_snap - last_cnt;
		fit = '0;
		for (int i = 0; i < `BP_LANES; i++)
		begin
			if (mask[i] && room > 0)
			begin
				fit[i] = 1'b1;
				room--;
			end
		end
		retire_valid <= fit;
		retire_taken <= taken;
		retire_pc <= pcs;
		last_cnt = $countones(fit);
		@(posedge clk);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			retire_valid <= '0;
			last_cnt = 0;
			@(posedge clk);
		end
	endtask

	// Returns on a rising edge once every retired branch has trained the table
	task automatic wait_drain();
		retire_valid <= '0;
		last_cnt = 0;
		do
			@(negedge clk);
		while (mdl_q_pc.size() != 0 || mdl_out_valid);
		@(posedge clk);
	endtask

	task automatic expect_predict(input logic [`BP_LANES-1:0] value);
		@(negedge clk);
		check_value("predict_taken", predict_taken, value);
		@(posedge clk);
	endtask

	// Four low address patterns with random upper bits, so entries are shared
	function automatic logic [`BP_ADDR_WIDTH-1:0] rand_pc();
		return ($urandom() << `BP_PC_BITS) | (32'h13 * $urandom_range(3, 0));
	endfunction

	// Mode 1 leans taken, mode 2 leans not-taken, otherwise even odds
	function automatic logic [`BP_LANES-1:0] pick_taken(input int mode);
		logic [`BP_LANES-1:0] tk;
		for (int i = 0; i < `BP_LANES; i++)
		begin
			case (mode)
				1: tk[i] = ($urandom_range(7, 0) != 0);
				2: tk[i] = ($urandom_range(7, 0) == 0);
				default: tk[i] = $urandom_range(1, 0);
			endcase
		end
		return tk;
	endfunction

	task automatic random_run(input int n, input int mode, input logic [`BP_LANES-1:0] force_mask);
		logic [`BP_LANES-1:0][`BP_ADDR_WIDTH-1:0] pcs;
		repeat (n)
		begin
			for (int i = 0; i < `BP_LANES; i++)
			begin
				pcs[i] = rand_pc();
				fetch_pc[i] <= rand_pc();
			end
			retire_cycle(`BP_LANES'($urandom()) | force_mask, pick_taken(mode), pcs);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial
	begin
		void'($urandom(50280));
		rst = 1'b1;
		en = 1'b1;
		retire_valid = '0;
		retire_taken = '0;
		retire_pc = '0;
		fetch_pc = '0;
		addr_a = 32'h0000_1040;
		addr_b = 32'h0000_2013;

		// Sweep length, then every low address pattern predicts not-taken
		reset_and_sweep();
		for (int k = 0; k < (1 << `BP_PC_BITS); k += `BP_LANES)
		begin
			for (int i = 0; i < `BP_LANES; i++)
				fetch_pc[i] <= ($urandom() << `BP_PC_BITS) | 32'(k + i);
			idle_cycles(1);
		end

		// Two taken retires of one address with history fixed at all ones
		fetch_pc <= {`BP_LANES{addr_a}};
		retire_cycle(4'b0011, 4'b0011, {`BP_LANES{addr_b}});
		wait_drain();
		retire_cycle(4'b0011, 4'b0011, {`BP_LANES{addr_a}});
		idle_cycles(1);
		// Old state while the first record is on the bus, taken once it is consumed
		expect_predict(4'h0);
		expect_predict(4'hf);
		wait_drain();

		// History of all zeros selects an untrained counter for the same address
		retire_cycle(4'b0011, 4'b0000, {`BP_LANES{addr_b}});
		wait_drain();
		expect_predict(4'h0);
		retire_cycle(4'b0011, 4'b0011, {`BP_LANES{addr_b}});
		wait_drain();
		expect_predict(4'hf);

		// The counter of addr_b under zero history is saturated taken here
		// A second reset must keep it hidden until the sweep has cleared it
		fetch_pc <= {`BP_LANES{addr_b}};
		reset_and_sweep();

		// Random masks, starting with all four lanes in one cycle
		random_run(1, 0, 4'hf);
		random_run(300, 0, 4'h0);
		wait_drain();

		// Training pauses while en is low and the buffer fills up
		en <= 1'b0;
		random_run(40, 0, 4'h0);
		en <= 1'b1;
		random_run(20, 0, 4'h0);
		wait_drain();

		// Lopsided runs push counters against both limits
		random_run(300, 1, 4'h0);
		random_run(300, 2, 4'h0);
		wait_drain();

		if (error_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
